//--- issue_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue stage package with thread geometry, register map,
// FP pipeline latencies and the shared issue types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package issue_pkg;

	// Number of hardware threads sharing the issue port
	localparam int THREAD_NUMB = 4;

	// The top address bit selects the vector file and the low bits the register index
	localparam int REG_ADDR_W = 6;

	// One busy bit per architectural register, scalar and vector together
	localparam int SCOREBOARD_LENGTH = 64;

	// Cycles from issue to FP result for each single precision operation
	localparam int FP_ADD_LAT  = 5;
	localparam int FP_MUL_LAT  = 4;
	localparam int FP_DIV_LAT  = 17;
	localparam int FP_CMP_LAT  = 1;
	localparam int FP_ITOF_LAT = 3;
	localparam int FP_FTOI_LAT = 3;

	// The pending queue must reach the slowest FP operation
	localparam int FP_QUEUE_LEN = 17;

	// Extra cycles a thread waits after its sync instruction leaves the stage
	localparam int SYNC_HOLD_CYCLES = 3;

	typedef logic [$clog2(THREAD_NUMB)-1:0] thread_id_t;
	typedef logic [THREAD_NUMB-1:0]         thread_mask_t;
	typedef logic [REG_ADDR_W-1:0]          reg_addr_t;
	typedef logic [SCOREBOARD_LENGTH-1:0]   scoreboard_t;

	// Subtraction goes down the adder and shares its encoding
	typedef enum logic [2:0] {
		FP_NONE = 3'd0,
		FP_ADD  = 3'd1,
		FP_MUL  = 3'd2,
		FP_DIV  = 3'd3,
		FP_CMP  = 3'd4,
		FP_ITOF = 3'd5,
		FP_FTOI = 3'd6
	} fp_op_t;

	// Result latency of an FP operation, zero when the instruction is not FP
	function automatic int unsigned fp_latency(fp_op_t op);
		int unsigned lat;
		case (op)
			FP_ADD:  lat = FP_ADD_LAT;
			FP_MUL:  lat = FP_MUL_LAT;
			FP_DIV:  lat = FP_DIV_LAT;
			FP_CMP:  lat = FP_CMP_LAT;
			FP_ITOF: lat = FP_ITOF_LAT;
			FP_FTOI: lat = FP_FTOI_LAT;
			default: lat = 0;
		endcase
		return lat;
	endfunction

	// Turns a register address into its single scoreboard bit
	function automatic scoreboard_t reg_onehot(reg_addr_t addr);
		scoreboard_t mask;
		mask = '0;
		mask[addr] = 1'b1;
		return mask;
	endfunction

endpackage

//--- thread_hazard_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Per-thread hazard unit with the register scoreboard,
// RAW and WAW checks, sync hold and issue eligibility
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module thread_hazard_unit
	import issue_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	// Decoded instruction from the instruction buffer
	input  logic        ib_valid,
	input  logic        has_src0,
	input  reg_addr_t   src0,
	input  logic        has_src1,
	input  reg_addr_t   src1,
	input  logic        has_dst,
	input  reg_addr_t   dst,
	input  logic        is_fp,
	// FP result slot is free for this thread's operation
	input  logic        fp_ok,
	// This thread's sync instruction sits in the output register
	input  logic        is_sync_issued,
	input  logic        granted,
	// Writeback release already decoded for this thread
	input  logic        wb_release,
	input  reg_addr_t   wb_register,
	input  logic        rb_valid,
	input  scoreboard_t rb_destination_mask,
	input  logic        wb_fifo_full,
	output logic        can_issue,
	output scoreboard_t destination_mask
);

	scoreboard_t scoreboard;
	scoreboard_t scoreboard_next;
	scoreboard_t source_mask;
	scoreboard_t release_mask;
	scoreboard_t rollback_mask;
	scoreboard_t set_mask;
	logic        hazard_raw;
	logic        hazard_waw;
	logic        fp_blocked;
	logic        sync_blocked;
	logic [1:0]  sync_count;

	// Each used operand becomes one bit in a scoreboard sized mask
	always_comb begin
		source_mask = '0;
		if (has_src0) begin
			source_mask = source_mask | reg_onehot(src0);
		end
		if (has_src1) begin
			source_mask = source_mask | reg_onehot(src1);
		end
	end

	assign destination_mask = has_dst ? reg_onehot(dst) : '0;

	// A source still waiting for a result is a RAW hazard
	assign hazard_raw = |(source_mask & scoreboard);
	// A destination with a write in flight is a WAW hazard
	assign hazard_waw = |(destination_mask & scoreboard);

	// Only FP instructions care about the shared result slot
	assign fp_blocked = is_fp && !fp_ok;

	// The sync blocks the thread while it is at the output and until the counter drains
	assign sync_blocked = is_sync_issued || (sync_count != 2'd0);

	assign can_issue = ib_valid && !hazard_raw && !hazard_waw && !wb_fifo_full
		&& !rb_valid && !fp_blocked && !sync_blocked;

	// Writeback frees one register and rollback frees a whole group
	assign release_mask  = wb_release ? reg_onehot(wb_register) : '0;
	assign rollback_mask = rb_valid ? rb_destination_mask : '0;
	assign set_mask      = granted ? destination_mask : '0;

	// Clears are applied first so a new reservation of the same register survives
	assign scoreboard_next = (scoreboard & ~(release_mask | rollback_mask)) | set_mask;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			scoreboard <= '0;
		end else begin
			scoreboard <= scoreboard_next;
		end
	end

	// Counter loads when the sync reaches the output and counts down to zero
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			sync_count <= 2'd0;
		end else if (is_sync_issued) begin
			sync_count <= 2'(SYNC_HOLD_CYCLES);
		end else if (sync_count != 2'd0) begin
			sync_count <= sync_count - 2'd1;
		end
	end

	// The arbiter must only pick a thread that this unit reports as eligible
	a_grant_needs_eligibility: assert property (
		@(posedge clk) disable iff (reset)
		granted |-> can_issue
	);

endmodule

//--- fp_result_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared FP result tracker that keeps two FP operations
// from reaching the single result port in one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module fp_result_tracker
	import issue_pkg::*;
(
	input  logic                       clk,
	input  logic                       reset,
	// Operation class of each thread's pending instruction
	input  fp_op_t [THREAD_NUMB-1:0]   fp_op,
	// One-hot grant from the arbiter
	input  thread_mask_t               grant,
	// High when the thread's FP op would find its result slot free
	output thread_mask_t               fp_ok
);

	// Bit i marks an FP result that arrives i+1 cycles from now
	logic [FP_QUEUE_LEN-1:0] pending_queue;
	logic [FP_QUEUE_LEN-1:0] reserve_mask;
	logic [FP_QUEUE_LEN-1:0] queue_next;

	// Each thread looks up the slot its own latency would land in
	always_comb begin
		int unsigned lat;
		fp_ok = '0;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			lat = fp_latency(fp_op[t]);
			if (lat == 0) begin
				fp_ok[t] = 1'b1;
			end else begin
				fp_ok[t] = !pending_queue[lat - 1];
			end
		end
	end

	// The granted thread claims the slot of its operation
	always_comb begin
		int unsigned lat;
		reserve_mask = '0;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			lat = fp_latency(fp_op[t]);
			if (grant[t] && (lat != 0)) begin
				reserve_mask[lat - 1] = 1'b1;
			end
		end
	end

	// The claim is merged before the shift, so it moves one step closer with the rest
	assign queue_next = (pending_queue | reserve_mask) >> 1;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			pending_queue <= '0;
		end else begin
			pending_queue <= queue_next;
		end
	end

	// A claimed slot must have been free, otherwise two results would meet at writeback
	a_no_double_reservation: assert property (
		@(posedge clk) disable iff (reset)
		(reserve_mask & pending_queue) == '0
	);

endmodule

//--- round_robin_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter giving a one-hot grant and its index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module round_robin_arbiter
	import issue_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  thread_mask_t requests,
	output thread_mask_t grant,
	output thread_id_t   grant_id
);

	// Thread that has highest priority in the current cycle
	thread_id_t priority_ptr;

	// Scan the requests starting at the priority pointer and take the first one
	always_comb begin
		thread_id_t idx;
		logic       found;
		grant    = '0;
		grant_id = '0;
		found    = 1'b0;
		for (int i = 0; i < THREAD_NUMB; i++) begin
			idx = thread_id_t'((int'(priority_ptr) + i) % THREAD_NUMB);
			if (!found && requests[idx]) begin
				found       = 1'b1;
				grant[idx]  = 1'b1;
				grant_id    = idx;
			end
		end
	end

	// Priority moves past the winner and stays put on idle cycles
	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			priority_ptr <= '0;
		end else if (|grant) begin
			if (grant_id == thread_id_t'(THREAD_NUMB - 1)) begin
				priority_ptr <= '0;
			end else begin
				priority_ptr <= grant_id + 1'b1;
			end
		end
	end

	a_grant_onehot_subset: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(grant) && ((grant & ~requests) == '0)
	);

endmodule

//--- instruction_scheduler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue stage top with per-thread hazard units, FP guard,
// round-robin thread pick and the operand fetch register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module instruction_scheduler
	import issue_pkg::*;
(
	input  logic                                clk,
	input  logic                                reset,
	// Decoded instructions, one slot per thread
	input  thread_mask_t                        ib_valid,
	input  thread_mask_t                        has_src0,
	input  reg_addr_t    [THREAD_NUMB-1:0]      src0,
	input  thread_mask_t                        has_src1,
	input  reg_addr_t    [THREAD_NUMB-1:0]      src1,
	input  thread_mask_t                        has_dst,
	input  reg_addr_t    [THREAD_NUMB-1:0]      dst,
	input  fp_op_t       [THREAD_NUMB-1:0]      fp_op,
	input  thread_mask_t                        is_sync,
	// Writeback release strobe and FIFO back-pressure
	input  logic                                wb_valid,
	input  thread_id_t                          wb_thread_id,
	input  reg_addr_t                           wb_register,
	input  logic                                wb_fifo_full,
	// Rollback clears of busy registers
	input  thread_mask_t                        rb_valid,
	input  scoreboard_t  [THREAD_NUMB-1:0]      rb_destination_mask,
	// Registered instruction toward operand fetch
	output logic                                is_instruction_valid,
	output thread_id_t                          is_thread_id,
	output reg_addr_t                           is_dst,
	output fp_op_t                              is_fp_op,
	output logic                                is_sync_op,
	output scoreboard_t                         is_destination_mask,
	// Grant back to the instruction buffer
	output thread_mask_t                        is_thread_scheduled_mask
);

	thread_mask_t                   can_issue;
	thread_mask_t                   grant;
	thread_id_t                     grant_id;
	thread_mask_t                   fp_ok;
	thread_mask_t                   wb_release;
	thread_mask_t                   sync_issued;
	scoreboard_t [THREAD_NUMB-1:0]  destination_mask;

	// Writeback and output sync are decoded once here for all threads
	always_comb begin
		for (int t = 0; t < THREAD_NUMB; t++) begin
			wb_release[t]  = wb_valid && (wb_thread_id == thread_id_t'(t));
			sync_issued[t] = is_instruction_valid && is_sync_op
				&& (is_thread_id == thread_id_t'(t));
		end
	end

	for (genvar t = 0; t < THREAD_NUMB; t++) begin : g_thread
		thread_hazard_unit u_hazard (
			.clk                 (clk),
			.reset               (reset),
			.ib_valid            (ib_valid[t]),
			.has_src0            (has_src0[t]),
			.src0                (src0[t]),
			.has_src1            (has_src1[t]),
			.src1                (src1[t]),
			.has_dst             (has_dst[t]),
			.dst                 (dst[t]),
			.is_fp               (fp_op[t] != FP_NONE),
			.fp_ok               (fp_ok[t]),
			.is_sync_issued      (sync_issued[t]),
			.granted             (grant[t]),
			.wb_release          (wb_release[t]),
			.wb_register         (wb_register),
			.rb_valid            (rb_valid[t]),
			.rb_destination_mask (rb_destination_mask[t]),
			.wb_fifo_full        (wb_fifo_full),
			.can_issue           (can_issue[t]),
			.destination_mask    (destination_mask[t])
		);
	end

	// All threads share one FP result port
	fp_result_tracker u_fp_tracker (
		.clk   (clk),
		.reset (reset),
		.fp_op (fp_op),
		.grant (grant),
		.fp_ok (fp_ok)
	);

	round_robin_arbiter u_arbiter (
		.clk      (clk),
		.reset    (reset),
		.requests (can_issue),
		.grant    (grant),
		.grant_id (grant_id)
	);

	// The buffer advances the granted thread at the next edge
	assign is_thread_scheduled_mask = grant;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			is_instruction_valid <= 1'b0;
		end else begin
			is_instruction_valid <= |grant;
		end
	end

	// Payload follows the arbiter index and is qualified by the valid bit
	always_ff @(posedge clk) begin
		is_thread_id        <= grant_id;
		is_dst              <= dst[grant_id];
		is_fp_op            <= fp_op[grant_id];
		is_sync_op          <= is_sync[grant_id];
		is_destination_mask <= destination_mask[grant_id];
	end

endmodule

//--- tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source for the issue stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen
	import issue_pkg::*;
(
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset covers four rising edges and drops on a falling edge
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

//--- instruction_scheduler_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Issue stage testbench with an instruction buffer model,
// a reference model of the scheduler and per-cycle checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module instruction_scheduler_tb
	import issue_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic      has_src0;
		reg_addr_t src0;
		logic      has_src1;
		reg_addr_t src1;
		logic      has_dst;
		reg_addr_t dst;
		fp_op_t    fp_op;
		logic      sync;
	} instr_t;

	logic                          clk;
	logic                          reset;
	thread_mask_t                  ib_valid;
	thread_mask_t                  has_src0;
	thread_mask_t                  has_src1;
	thread_mask_t                  has_dst;
	thread_mask_t                  is_sync;
	reg_addr_t    [THREAD_NUMB-1:0] src0;
	reg_addr_t    [THREAD_NUMB-1:0] src1;
	reg_addr_t    [THREAD_NUMB-1:0] dst;
	fp_op_t       [THREAD_NUMB-1:0] fp_op;
	logic                          wb_valid;
	thread_id_t                    wb_thread_id;
	reg_addr_t                     wb_register;
	logic                          wb_fifo_full;
	thread_mask_t                  rb_valid;
	scoreboard_t  [THREAD_NUMB-1:0] rb_destination_mask;
	logic                          is_instruction_valid;
	thread_id_t                    is_thread_id;
	reg_addr_t                     is_dst;
	fp_op_t                        is_fp_op;
	logic                          is_sync_op;
	scoreboard_t                   is_destination_mask;
	thread_mask_t                  is_thread_scheduled_mask;

	// Instruction buffer, one queue per thread
	instr_t       ib_q [THREAD_NUMB][$];
	thread_mask_t granted_dut;
	int           cycle;
	int           grant_cycle [THREAD_NUMB];
	int           value_errors;
	int           other_errors;
	logic [31:0]  lcg_state;

	// Reference model state, updated once per clock edge
	scoreboard_t             sb [THREAD_NUMB];
	int                      sync_cnt [THREAD_NUMB];
	logic [FP_QUEUE_LEN-1:0] fpq;
	int                      ptr;
	logic                    exp_valid;
	thread_id_t              exp_tid;
	reg_addr_t               exp_dst;
	fp_op_t                  exp_fp;
	logic                    exp_sync;
	scoreboard_t             exp_mask;

	tb_clock_gen clock_gen (.clk(clk), .reset(reset));

	instruction_scheduler uut (.*);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Result delay of each FP class, zero for integer instructions
	function automatic int result_delay(fp_op_t op);
		case (op)
			FP_ADD:  return FP_ADD_LAT;
			FP_MUL:  return FP_MUL_LAT;
			FP_DIV:  return FP_DIV_LAT;
			FP_CMP:  return FP_CMP_LAT;
			FP_ITOF: return FP_ITOF_LAT;
			FP_FTOI: return FP_FTOI_LAT;
			default: return 0;
		endcase
	endfunction

	// A negative register number means the operand is unused
	function automatic instr_t make_op(int d, int a, int b, fp_op_t op = FP_NONE,
		logic s = 1'b0);
		instr_t i;
		i.has_dst  = (d >= 0);
		i.dst      = reg_addr_t'((d < 0) ? 0 : d);
		i.has_src0 = (a >= 0);
		i.src0     = reg_addr_t'((a < 0) ? 0 : a);
		i.has_src1 = (b >= 0);
		i.src1     = reg_addr_t'((b < 0) ? 0 : b);
		i.fp_op    = op;
		i.sync     = s;
		return i;
	endfunction

	// Sixteen registers, half scalar and half vector, so hazards are frequent
	function automatic int pick_reg(logic [3:0] x);
		return int'({x[3], 2'b00, x[2:0]});
	endfunction

	function automatic instr_t random_instr(logic [31:0] v);
		fp_op_t op;
		op = FP_NONE;
		if (v[3:0] > 4'd9) begin
			op = fp_op_t'(int'(v[6:4]) % 6 + 1);
		end
		return make_op(v[7] ? pick_reg(v[11:8]) : -1, v[20] ? pick_reg(v[15:12]) : -1,
			v[21] ? pick_reg(v[19:16]) : -1, op, v[31:26] == 6'd0);
	endfunction

	// Reference of the issue rules, gives the one-hot grant of this cycle
	function automatic thread_mask_t expected_grant();
		thread_mask_t elig;
		int           lat;
		int           idx;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			lat = result_delay(fp_op[t]);
			elig[t] = ib_valid[t] && !wb_fifo_full && !rb_valid[t] && (sync_cnt[t] == 0)
				&& !(exp_valid && exp_sync && exp_tid == thread_id_t'(t))
				&& !(has_src0[t] && sb[t][src0[t]]) && !(has_src1[t] && sb[t][src1[t]])
				&& !(has_dst[t] && sb[t][dst[t]]) && (lat == 0 || !fpq[lat - 1]);
		end
		for (int i = 0; i < THREAD_NUMB; i++) begin
			idx = (ptr + i) % THREAD_NUMB;
			if (elig[idx]) begin
				return thread_mask_t'(1 << idx);
			end
		end
		return '0;
	endfunction

	// Mirrors what the clock edge does to the scheduler state
	task automatic advance_model(thread_mask_t g);
		logic [FP_QUEUE_LEN-1:0] claim;
		int                      lat;
		int                      winner;
		claim  = '0;
		winner = -1;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			if (exp_valid && exp_sync && exp_tid == thread_id_t'(t)) begin
				sync_cnt[t] = SYNC_HOLD_CYCLES;
			end else if (sync_cnt[t] > 0) begin
				sync_cnt[t]--;
			end
			if (wb_valid && wb_thread_id == thread_id_t'(t)) begin
				sb[t][wb_register] = 1'b0;
			end
			if (rb_valid[t]) begin
				sb[t] = sb[t] & ~rb_destination_mask[t];
			end
			// The new reservation is applied after the clears
			if (g[t]) begin
				winner = t;
				if (has_dst[t]) begin
					sb[t][dst[t]] = 1'b1;
				end
				lat = result_delay(fp_op[t]);
				if (lat != 0) begin
					claim[lat - 1] = 1'b1;
				end
			end
		end
		fpq       = (fpq | claim) >> 1;
		exp_valid = (winner >= 0);
		if (winner >= 0) begin
			ptr      = (winner + 1) % THREAD_NUMB;
			exp_tid  = thread_id_t'(winner);
			exp_dst  = dst[winner];
			exp_fp   = fp_op[winner];
			exp_sync = is_sync[winner];
			exp_mask = has_dst[winner] ? (scoreboard_t'(1) << dst[winner]) : '0;
		end
	endtask

	task automatic check_valid(string name, logic got, logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_thread(string name, thread_id_t got, thread_id_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_fp(string name, fp_op_t got, fp_op_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_mask(string name, scoreboard_t got, scoreboard_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_grant(string name, thread_mask_t got, thread_mask_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("Fail at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic expect_cycle(string what, int got, int exp);
		if (got != exp) begin
			other_errors++;
			$display("The %s was granted in cycle %0d instead of cycle %0d", what, got, exp);
		end
	endtask

	// Drives each thread's oldest buffered instruction, or nothing
	task automatic present();
		instr_t cur;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			cur = (ib_q[t].size() > 0) ? ib_q[t][0] : '0;
			ib_valid[t] = (ib_q[t].size() > 0);
			has_src0[t] = cur.has_src0;
			src0[t]     = cur.src0;
			has_src1[t] = cur.has_src1;
			src1[t]     = cur.src1;
			has_dst[t]  = cur.has_dst;
			dst[t]      = cur.dst;
			fp_op[t]    = cur.fp_op;
			is_sync[t]  = cur.sync;
		end
	endtask

	// Moves to the next falling edge; a thread granted in the last cycle advances
	task automatic step();
		@(negedge clk);
		cycle++;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			if (granted_dut[t] && ib_q[t].size() > 0) begin
				void'(ib_q[t].pop_front());
			end
		end
		present();
	endtask

	// Writeback of one register that the model still holds busy
	task automatic release_busy(int t, int start);
		int r;
		wb_valid = 1'b0;
		for (int i = 0; i < SCOREBOARD_LENGTH; i++) begin
			r = (start + i) % SCOREBOARD_LENGTH;
			if (!wb_valid && sb[t][r]) begin
				wb_valid     = 1'b1;
				wb_thread_id = thread_id_t'(t);
				wb_register  = reg_addr_t'(r);
			end
		end
	endtask

	task automatic wait_grant(int t);
		int start;
		int i;
		start = cycle;
		for (i = 0; i < 100; i++) begin
			step();
			if (grant_cycle[t] >= start) begin
				break;
			end
		end
		if (i == 100) begin
			other_errors++;
			$display("Timeout while thread %0d waited for a grant", t);
		end
	endtask

	// Runs until every buffer is empty, releasing busy registers on the way
	task automatic drain();
		int i;
		for (i = 0; i < 200; i++) begin
			if (ib_q[0].size() + ib_q[1].size() + ib_q[2].size() + ib_q[3].size() == 0) begin
				break;
			end
			release_busy(i % THREAD_NUMB, 0);
			step();
		end
		wb_valid = 1'b0;
		if (i == 200) begin
			other_errors++;
			$display("Timeout while the instruction buffers drained");
		end
	endtask

	// Rollback of every register of every thread
	task automatic clear_all();
		rb_valid = '1;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			rb_destination_mask[t] = '1;
		end
		step();
		rb_valid = '0;
	endtask

	// Compares in the middle of the low clock phase, where all values are settled
	always begin
		thread_mask_t g;
		@(negedge clk);
		#2;
		if (!reset) begin
			g = expected_grant();
			check_grant("is_thread_scheduled_mask", is_thread_scheduled_mask, g);
			check_valid("is_instruction_valid", is_instruction_valid, exp_valid);
			if (exp_valid && is_instruction_valid) begin
				check_thread("is_thread_id", is_thread_id, exp_tid);
				check_reg("is_dst", is_dst, exp_dst);
				check_fp("is_fp_op", is_fp_op, exp_fp);
				check_valid("is_sync_op", is_sync_op, exp_sync);
				check_mask("is_destination_mask", is_destination_mask, exp_mask);
			end
			granted_dut = is_thread_scheduled_mask;
			for (int t = 0; t < THREAD_NUMB; t++) begin
				if (granted_dut[t]) begin
					grant_cycle[t] = cycle;
				end
			end
			advance_model(g);
		end
	end

	initial begin
		int          mark;
		int          n;
		logic [31:0] v;
		lcg_state    = 32'h5afb_2dc4;
		cycle        = 0;
		value_errors = 0;
		other_errors = 0;
		granted_dut  = '0;
		fpq          = '0;
		ptr          = 0;
		exp_valid    = 1'b0;
		for (int t = 0; t < THREAD_NUMB; t++) begin
			sb[t]                  = '0;
			sync_cnt[t]            = 0;
			grant_cycle[t]         = -1;
			rb_destination_mask[t] = '0;
		end
		wb_valid     = 1'b0;
		wb_thread_id = '0;
		wb_register  = '0;
		wb_fifo_full = 1'b0;
		rb_valid     = '0;
		present();
		n = 0;
		while (reset && n < 20) begin
			@(posedge clk);
			n++;
		end
		if (reset) begin
			other_errors++;
			$display("Reset never dropped");
		end

		// Idle buffers give no grant and no output
		repeat (4) step();

		// Independent instructions rotate through the threads
		for (int t = 0; t < THREAD_NUMB; t++) begin
			ib_q[t].push_back(make_op(t + 1, -1, -1));
		end
		ib_q[0].push_back(make_op(9, -1, -1));
		drain();
		clear_all();

		// Reader of r5 waits for the writeback of r5
		ib_q[0].push_back(make_op(5, -1, -1));
		ib_q[0].push_back(make_op(6, 5, -1));
		wait_grant(0);
		repeat (4) step();
		mark         = cycle;
		wb_valid     = 1'b1;
		wb_thread_id = 2'd0;
		wb_register  = 6'd5;
		step();
		wb_valid = 1'b0;
		wait_grant(0);
		expect_cycle("reader after writeback", grant_cycle[0], mark + 1);
		clear_all();

		// A full writeback FIFO stops every thread
		wb_fifo_full = 1'b1;
		ib_q[1].push_back(make_op(12, -1, -1));
		ib_q[2].push_back(make_op(13, 3, -1));
		repeat (5) step();
		wb_fifo_full = 1'b0;
		drain();
		clear_all();

		// Rollback frees the blocked reader, but not in the rollback cycle
		ib_q[2].push_back(make_op(7, -1, -1));
		ib_q[2].push_back(make_op(8, 7, -1));
		wait_grant(2);
		repeat (3) step();
		rb_valid[2]               = 1'b1;
		rb_destination_mask[2]    = scoreboard_t'(1) << 7;
		mark                      = cycle;
		step();
		rb_valid = '0;
		wait_grant(2);
		expect_cycle("reader after rollback", grant_cycle[2], mark + 1);
		drain();
		clear_all();

		// Sync holds thread 3 while thread 0 keeps issuing
		ib_q[3].push_back(make_op(-1, -1, -1, FP_NONE, 1'b1));
		ib_q[3].push_back(make_op(9, -1, -1));
		for (int r = 10; r < 16; r++) begin
			ib_q[0].push_back(make_op(r, -1, -1));
		end
		wait_grant(3);
		mark = grant_cycle[3];
		wait_grant(3);
		expect_cycle("instruction after sync", grant_cycle[3], mark + SYNC_HOLD_CYCLES + 2);
		drain();
		clear_all();

		// An add offered 12 cycles after a div would meet it at the result port
		ib_q[0].push_back(make_op(20, -1, -1, FP_DIV));
		wait_grant(0);
		mark = grant_cycle[0];
		for (int i = 0; i < 20 && cycle < mark + 11; i++) begin
			step();
		end
		ib_q[1].push_back(make_op(21, -1, -1, FP_ADD));
		wait_grant(1);
		expect_cycle("FP add", grant_cycle[1], mark + 13);
		drain();
		clear_all();

		// Random traffic against the reference model
		for (int c = 0; c < 400; c++) begin
			for (int t = 0; t < THREAD_NUMB; t++) begin
				if (ib_q[t].size() < 2) begin
					ib_q[t].push_back(random_instr(next_random()));
				end
			end
			v = next_random();
			if (v[8]) begin
				release_busy(int'(v[1:0]), int'(v[7:2]));
			end else begin
				wb_valid = 1'b0;
			end
			rb_valid = (v[14:10] == 5'd0) ? thread_mask_t'(1 << v[16:15]) : '0;
			rb_destination_mask[v[16:15]] = {next_random(), next_random()};
			wb_fifo_full = (v[20:17] == 4'd0);
			step();
		end
		rb_valid     = '0;
		wb_fifo_full = 1'b0;
		drain();
		repeat (2) step();

		$display("Errors: %0d value mismatches, %0d timing or timeout failures",
			value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

//--- instruction_scheduler.f
issue_pkg.sv
thread_hazard_unit.sv
fp_result_tracker.sv
round_robin_arbiter.sv
instruction_scheduler.sv
tb_clock_gen.sv
instruction_scheduler_tb.sv

//--- Bender.yml
package:
  name: instruction_scheduler

sources:
  - files:
      - issue_pkg.sv
      - thread_hazard_unit.sv
      - fp_result_tracker.sv
      - round_robin_arbiter.sv
      - instruction_scheduler.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - instruction_scheduler_tb.sv
